// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
LINTFLAGS = --lint-only --timing --assert
TOP       = tb_alpha_frontend
FILELIST  = tb.f
OBJ_DIR   = obj_dir
PASS_MSG  = Simulation PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

# pass only when the simulation output holds the pass message
run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR)

// File: dv/tb_decode_model.svh
//**************************************************************************
// Testbench decode model: LCG random source, instruction generator and
// expected decode outputs for one IF/ID word
//**************************************************************************

`ifndef TB_DECODE_MODEL_SVH
`define TB_DECODE_MODEL_SVH

	// listed operate function codes per group
	localparam logic [6:0] INTA_FUNCS [0:6] = '{`ADDQ_INST, `SUBQ_INST, `CMPEQ_INST,
		`CMPULT_INST, `CMPULE_INST, `CMPLT_INST, `CMPLE_INST};
	localparam logic [6:0] INTL_FUNCS [0:5] = '{`AND_INST, `BIC_INST, `BIS_INST,
		`ORNOT_INST, `XOR_INST, `EQV_INST};
	localparam logic [6:0] INTS_FUNCS [0:2] = '{`SRL_INST, `SLL_INST, `SRA_INST};
	localparam logic [5:0] MEM_OPS [0:4] = '{`LDA_INST, `LDQ_INST, `LDQ_L_INST,
		`STQ_INST, `STQ_C_INST};
	localparam logic [5:0] FP_OPS [0:11] = '{`ITFP_GRP, `FLTV_GRP, `FLTI_GRP, `FLTL_GRP,
		`MISC_GRP, `FTPI_GRP, `FBEQ_INST, `FBLT_INST, `FBLE_INST, `FBNE_INST,
		`FBGE_INST, `FBGT_INST};

	function automatic logic [31:0] rand32();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	function automatic int rand_below(input int n);
		logic [31:0] r;
		r = rand32();
		return int'(r[30:8]) % n;   // low LCG bits are weak
	endfunction

	function automatic logic func_listed(input logic [5:0] op, input logic [6:0] func);
		logic hit;
		hit = 1'b0;
		case (op)
			`INTA_GRP: for (int i = 0; i < 7; i++) hit |= (INTA_FUNCS[i] == func);
			`INTL_GRP: for (int i = 0; i < 6; i++) hit |= (INTL_FUNCS[i] == func);
			`INTS_GRP: for (int i = 0; i < 3; i++) hit |= (INTS_FUNCS[i] == func);
			`INTM_GRP: hit = (func == `MULQ_INST);
			default:   hit = 1'b0;
		endcase
		return hit;
	endfunction

	function automatic logic [6:0] pick_func(input logic [5:0] op);
		case (op)
			`INTA_GRP: return INTA_FUNCS[rand_below(7)];
			`INTL_GRP: return INTL_FUNCS[rand_below(6)];
			`INTS_GRP: return INTS_FUNCS[rand_below(3)];
			default:   return `MULQ_INST;
		endcase
	endfunction

	//**********************************************************************
	// random word: class first, then fields
	//**********************************************************************
	function automatic logic [31:0] gen_inst();
		alpha_pkg::inst_word_u w;
		logic [31:0]           r;
		logic [25:0]           pal;
		r = rand32();
		w = r;
		case (rand_below(10))
			0, 1, 2:
			begin
				w.op_fmt.opcode = `INTA_GRP + 6'(rand_below(4));
				if (rand_below(4) != 0)
					w.op_fmt.func = pick_func(w.op_fmt.opcode);   // else random, maybe unlisted
			end
			3, 4: w.mem_fmt.opcode = MEM_OPS[rand_below(5)];
			5:    w.op_fmt.opcode = `JSR_GRP;
			6:
			begin
				if (rand_below(3) == 0)
					w.br_fmt.opcode = (rand_below(2) == 0) ? `BR_INST : `BSR_INST;
				else
					w.br_fmt.opcode = 6'h38 + 6'(rand_below(8));   // integer cond branches
			end
			7:    w.op_fmt.opcode = FP_OPS[rand_below(12)];
			8:
			begin
				pal = (rand_below(2) == 0) ? `PAL_WHAMI : r[25:0];
				if (pal == `PAL_HALT)
					pal = pal ^ 26'h1;   // halt only at the end
				w = {`PAL_INST, pal};
			end
			default:
			begin
				if (w.op_fmt.opcode == `PAL_INST)
					w.op_fmt.opcode = 6'h01;   // any word but a PAL one
			end
		endcase
		return w;
	endfunction

	//**********************************************************************
	// expected decode of one IF/ID word, exp_test picks the test it counts for
	//**********************************************************************
	task automatic decode_expect(input logic [31:0] word, input logic valid);
		alpha_pkg::inst_word_u w;
		logic [5:0]            op;
		w          = word;
		op         = w.op_fmt.opcode;
		exp_ra     = `ZERO_REG;
		exp_rb     = `ZERO_REG;
		exp_dest   = `ZERO_REG;
		exp_fu     = alpha_pkg::FU_NONE;
		exp_rd     = 1'b0;
		exp_wr     = 1'b0;
		exp_ldl    = 1'b0;
		exp_stc    = 1'b0;
		exp_cond   = 1'b0;
		exp_uncond = 1'b0;
		exp_halt   = 1'b0;
		exp_cpuid  = 1'b0;
		exp_illeg  = 1'b0;
		exp_test   = 1;                            // noop
		if (valid)
		begin
			exp_test = 4;
			if (op == `PAL_INST)
			begin
				if (word[25:0] == `PAL_HALT)
				begin
					exp_halt = 1'b1;
					exp_test = 6;
				end
				else if (word[25:0] == `PAL_WHAMI)
				begin
					exp_cpuid = 1'b1;
					exp_dest  = w.op_fmt.ra;
				end
				else
					exp_illeg = 1'b1;
			end
			else if (op >= `INTA_GRP && op <= `INTM_GRP)
			begin
				// indices and unit come out even for an unlisted function
				exp_test  = 2;
				exp_ra    = w.op_fmt.ra;
				exp_rb    = w.op_fmt.lit ? `ZERO_REG : w.op_fmt.rb;
				exp_dest  = w.op_fmt.rc;
				exp_fu    = (op == `INTM_GRP) ? alpha_pkg::FU_MULT : alpha_pkg::FU_ALU;
				exp_illeg = !func_listed(op, w.op_fmt.func);
			end
			else if (op == `LDA_INST || op == `LDQ_INST || op == `LDQ_L_INST ||
				op == `STQ_INST || op == `STQ_C_INST)
			begin
				exp_test = 3;
				exp_rb   = w.mem_fmt.rb;                           // base
				exp_rd   = (op == `LDQ_INST || op == `LDQ_L_INST);
				exp_ldl  = (op == `LDQ_L_INST);
				exp_wr   = (op == `STQ_INST || op == `STQ_C_INST);
				exp_stc  = (op == `STQ_C_INST);
				exp_dest = (op == `STQ_INST) ? `ZERO_REG : w.mem_fmt.ra;
				if (exp_rd)
					exp_fu = alpha_pkg::FU_LOAD;
				else if (exp_wr)
					exp_fu = alpha_pkg::FU_STORE;
				else
					exp_fu = alpha_pkg::FU_ALU;                    // LDA
			end
			else if (op == `JSR_GRP || op == `BR_INST || op == `BSR_INST)
			begin
				exp_test   = 3;
				exp_rb     = (op == `JSR_GRP) ? w.op_fmt.rb : `ZERO_REG;
				exp_dest   = w.br_fmt.ra;                          // link register
				exp_uncond = 1'b1;
				exp_fu     = alpha_pkg::FU_UNCOND_BRANCH;
			end
			else if (op[5:3] == 3'b111)
			begin
				exp_test = 3;
				exp_cond = 1'b1;
				exp_fu   = alpha_pkg::FU_COND_BRANCH;
			end
			else
				exp_illeg = 1'b1;                                  // FP, MISC, reserved
		end
		exp_valid = valid && !exp_illeg;
	endtask

`endif

// File: dv/tb_alpha_frontend.sv
//**************************************************************************
// Front end testbench: clock, reset, memory model, random stall stimulus,
// per-cycle checks against the decode model, timeout and closing report
//**************************************************************************

`timescale 1ns/1ps
`include "alpha_macros.svh"

module tb_alpha_frontend;

	localparam int          MEM_WORDS      = 256;
	localparam int          HALT_IDX       = MEM_WORDS - 1;     // halt word sits last
	localparam int          RESET_CYCLES   = 5;
	localparam int          POST_HALT      = 8;                 // cycles watched after halt
	localparam int          TIMEOUT_CYCLES = MEM_WORDS + MEM_WORDS / 4 + 80;
	localparam logic [63:0] MEM_END        = 64'(MEM_WORDS * 4);
	localparam logic [63:0] HALT_PC        = 64'((HALT_IDX + 1) * 4);  // pc parks here

	logic clock, reset_i, stall_i, imem_valid_i;
	alpha_pkg::inst_word_u imem_data_i;
	logic [63:0] imem_addr_o;
	logic [4:0] id_ra_idx_o, id_rb_idx_o, id_dest_idx_o;
	alpha_pkg::fu_sel_e id_fu_sel_o;
	alpha_pkg::inst_word_u id_ir_o;
	logic id_rd_mem_o, id_wr_mem_o, id_ldl_mem_o, id_stc_mem_o, id_cond_branch_o;
	logic id_uncond_branch_o, id_halt_o, id_cpuid_o, id_illegal_o, id_valid_inst_o;

	logic [31:0] mem [0:MEM_WORDS-1];
	logic [31:0] lcg_state;
	logic [63:0] m_pc;          // model pc, IF/ID word, valid bit, halt latch
	logic [31:0] m_ir;
	logic m_valid, m_halted, hold_exp;
	logic [4:0] exp_ra, exp_rb, exp_dest;
	alpha_pkg::fu_sel_e exp_fu;
	logic exp_rd, exp_wr, exp_ldl, exp_stc, exp_cond, exp_uncond;
	logic exp_halt, exp_cpuid, exp_illeg, exp_valid;
	int exp_test, cycle_cnt, post_halt;
	int errs [1:6];
	int seen [1:6];
	logic [123:0] prev_obs;

	`include "tb_decode_model.svh"

	alpha_frontend i_alpha_frontend (
		.clock (clock), .reset_i (reset_i), .stall_i (stall_i),
		.imem_data_i (imem_data_i), .imem_valid_i (imem_valid_i), .imem_addr_o (imem_addr_o),
		.id_ra_idx_o (id_ra_idx_o), .id_rb_idx_o (id_rb_idx_o),
		.id_dest_idx_o (id_dest_idx_o), .id_fu_sel_o (id_fu_sel_o), .id_ir_o (id_ir_o),
		.id_rd_mem_o (id_rd_mem_o), .id_wr_mem_o (id_wr_mem_o),
		.id_ldl_mem_o (id_ldl_mem_o), .id_stc_mem_o (id_stc_mem_o),
		.id_cond_branch_o (id_cond_branch_o), .id_uncond_branch_o (id_uncond_branch_o),
		.id_halt_o (id_halt_o), .id_cpuid_o (id_cpuid_o),
		.id_illegal_o (id_illegal_o), .id_valid_inst_o (id_valid_inst_o)
	);

	initial
	begin
		clock = 1'b0;
		forever #50 clock = ~clock;   // 100 ns
	end

	task automatic check_field(input string name, input logic [63:0] act,
		input logic [63:0] exp, input int t);
		assert (act === exp)
		else
		begin
			$display("FAIL %s expected %h actual %h at cycle %0d", name, exp, act, cycle_cnt);
			errs[t]++;
		end
	endtask

	// what the edge just did, from the inputs held across it
	task automatic model_step();
		decode_expect(m_ir, m_valid);
		hold_exp = stall_i && !reset_i && !exp_halt;
		if (reset_i)
		begin
			m_pc     = `RESET_PC;
			m_valid  = 1'b0;
			m_halted = 1'b0;
		end
		else if (exp_halt || m_halted)
		begin
			m_halted = 1'b1;
			m_valid  = 1'b0;
		end
		else if (!stall_i)
		begin
			m_pc    = m_pc + 64'd4;
			m_valid = imem_valid_i;
			m_ir    = imem_data_i;
		end
	endtask

	task automatic drive_inputs();
		logic [63:0] a;
		a = imem_addr_o;
		imem_valid_i = (a < MEM_END);                 // nothing mapped past the array
		imem_data_i  = (a < MEM_END) ? mem[a[9:2]] : 32'h0;
		stall_i      = reset_i ? 1'b0 : (rand_below(8) == 0);
	endtask

	task automatic step_edge();
		@(posedge clock);
		model_step();
		#1;
		drive_inputs();
	endtask

	//**********************************************************************
	// per-cycle compare, sampled at the falling edge
	//**********************************************************************
	task automatic check_cycle();
		int           t;
		logic [123:0] obs;
		decode_expect(m_ir, m_valid);
		t = m_halted ? 6 : (hold_exp ? 5 : exp_test);
		seen[t]++;
		obs = {imem_addr_o, id_ra_idx_o, id_rb_idx_o, id_dest_idx_o, id_fu_sel_o, id_ir_o,
			id_rd_mem_o, id_wr_mem_o, id_ldl_mem_o, id_stc_mem_o, id_cond_branch_o,
			id_uncond_branch_o, id_halt_o, id_cpuid_o, id_illegal_o, id_valid_inst_o};
		check_field("imem_addr_o", imem_addr_o, m_pc, t);
		check_field("id_ra_idx_o", 64'(id_ra_idx_o), 64'(exp_ra), t);
		check_field("id_rb_idx_o", 64'(id_rb_idx_o), 64'(exp_rb), t);
		check_field("id_dest_idx_o", 64'(id_dest_idx_o), 64'(exp_dest), t);
		check_field("id_fu_sel_o", 64'(id_fu_sel_o), 64'(exp_fu), t);
		check_field("id_rd_mem_o", 64'(id_rd_mem_o), 64'(exp_rd), t);
		check_field("id_wr_mem_o", 64'(id_wr_mem_o), 64'(exp_wr), t);
		check_field("id_ldl_mem_o", 64'(id_ldl_mem_o), 64'(exp_ldl), t);
		check_field("id_stc_mem_o", 64'(id_stc_mem_o), 64'(exp_stc), t);
		check_field("id_cond_branch_o", 64'(id_cond_branch_o), 64'(exp_cond), t);
		check_field("id_uncond_branch_o", 64'(id_uncond_branch_o), 64'(exp_uncond), t);
		check_field("id_halt_o", 64'(id_halt_o), 64'(exp_halt), t);
		check_field("id_cpuid_o", 64'(id_cpuid_o), 64'(exp_cpuid), t);
		check_field("id_illegal_o", 64'(id_illegal_o), 64'(exp_illeg), t);
		check_field("id_valid_inst_o", 64'(id_valid_inst_o), 64'(exp_valid), t);
		if (m_valid)
			check_field("id_ir_o", 64'(id_ir_o), 64'(m_ir), t);
		if (hold_exp)
			assert (obs === prev_obs)
			else
			begin
				$display("stall did not hold the fetch and decode outputs at cycle %0d", cycle_cnt);
				errs[5]++;
			end
		if (m_halted)
		begin
			post_halt++;
			assert (imem_addr_o === HALT_PC && id_valid_inst_o === 1'b0)
			else
			begin
				$display("fetch moved or a valid word showed after halt at cycle %0d", cycle_cnt);
				errs[6]++;
			end
		end
		prev_obs = obs;
	endtask

	function automatic string test_name(input int t);
		case (t)
			1:       return "reset state";
			2:       return "operate decode";
			3:       return "memory and branch decode";
			4:       return "illegal and PAL decode";
			5:       return "stall hold";
			default: return "halt";
		endcase
	endfunction

	initial
	begin : watchdog
		cycle_cnt = 0;
		while (cycle_cnt < TIMEOUT_CYCLES)
		begin
			@(posedge clock);
			cycle_cnt++;
		end
		$display("timeout, no end of run after %0d cycles", TIMEOUT_CYCLES);
		$display("Simulation FAILED");
		$finish;
	end

	initial
	begin : main
		int total;
		int missing;
		reset_i      = 1'b1;
		stall_i      = 1'b0;
		imem_valid_i = 1'b0;
		imem_data_i  = 32'h0;
		lcg_state    = 32'hc4d8_d298;
		m_pc         = `RESET_PC;
		m_ir         = 32'h0;
		m_valid      = 1'b0;
		m_halted     = 1'b0;
		hold_exp     = 1'b0;
		post_halt    = 0;
		total        = 0;
		missing      = 0;
		for (int t = 1; t <= 6; t++)
		begin
			errs[t] = 0;
			seen[t] = 0;
		end
		for (int i = 0; i < HALT_IDX; i++)
			mem[i] = gen_inst();
		mem[HALT_IDX] = {`PAL_INST, `PAL_HALT};

		repeat (RESET_CYCLES) step_edge();
		reset_i = 1'b0;
		@(negedge clock);
		check_cycle();
		$display("test 1 %s: %0d errors", test_name(1), errs[1]);

		while (post_halt < POST_HALT)
		begin
			step_edge();
			@(negedge clock);
			check_cycle();
		end

		for (int t = 1; t <= 6; t++)
		begin
			total += errs[t];
			if (t > 1)
				$display("test %0d %s: %0d cycles, %0d errors", t, test_name(t), seen[t], errs[t]);
			if (seen[t] == 0)
			begin
				$display("test %0d had no cycles to check", t);
				missing++;
			end
		end
		$display("tests 6, cycles %0d, errors %0d, empty tests %0d", cycle_cnt, total, missing);
		if (total == 0 && missing == 0)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end

endmodule

// File: include/alpha_macros.svh
//**************************************************************************
// Alpha subset encodings: major opcodes, operate function codes, PAL codes
// Field widths, zero register, FU select width and reset PC
//**************************************************************************

`ifndef ALPHA_MACROS_SVH
`define ALPHA_MACROS_SVH

// field widths
`define OPCODE_W    6               // major opcode
`define REG_IDX_W   5               // register index
`define FUNC_W      7               // operate function code
`define MEM_DISP_W  16              // memory displacement
`define BR_DISP_W   21              // branch displacement
`define PC_W        64
`define FU_SEL_W    3               // functional-unit select

`define ZERO_REG    5'd31           // always ready, reads as zero
`define RESET_PC    64'h0

// major opcodes
`define PAL_INST    6'h00
`define LDA_INST    6'h08
`define INTA_GRP    6'h10           // integer arithmetic
`define INTL_GRP    6'h11           // integer logical
`define INTS_GRP    6'h12           // integer shift
`define INTM_GRP    6'h13           // integer multiply
`define ITFP_GRP    6'h14
`define FLTV_GRP    6'h15
`define FLTI_GRP    6'h16
`define FLTL_GRP    6'h17
`define MISC_GRP    6'h18
`define JSR_GRP     6'h1a           // JMP, JSR, RET, JSR_CO
`define FTPI_GRP    6'h1c
`define LDQ_INST    6'h29
`define LDQ_L_INST  6'h2b
`define STQ_INST    6'h2d
`define STQ_C_INST  6'h2f
`define BR_INST     6'h30
`define FBEQ_INST   6'h31
`define FBLT_INST   6'h32
`define FBLE_INST   6'h33
`define BSR_INST    6'h34
`define FBNE_INST   6'h35
`define FBGE_INST   6'h36
`define FBGT_INST   6'h37

// operate function codes, per group
`define ADDQ_INST   7'h20           // INTA
`define SUBQ_INST   7'h29
`define CMPEQ_INST  7'h2d
`define CMPULT_INST 7'h1d
`define CMPULE_INST 7'h3d
`define CMPLT_INST  7'h4d
`define CMPLE_INST  7'h6d
`define AND_INST    7'h00           // INTL
`define BIC_INST    7'h08
`define BIS_INST    7'h20
`define ORNOT_INST  7'h28
`define XOR_INST    7'h40
`define EQV_INST    7'h48
`define SRL_INST    7'h34           // INTS
`define SLL_INST    7'h39
`define SRA_INST    7'h3c
`define MULQ_INST   7'h20           // INTM

// PAL functions
`define PAL_HALT    26'h555
`define PAL_WHAMI   26'h3c

`endif

// File: src/alpha_frontend.sv
//**************************************************************************
// Front end top, fetch and decode stages wired to memory and back end
//**************************************************************************

`timescale 1ns/1ps
`include "alpha_macros.svh"

module alpha_frontend (
	input  logic                   clock,
	input  logic                   reset_i,
	input  logic                   stall_i,             // from back end
	input  alpha_pkg::inst_word_u  imem_data_i,         // same-cycle memory reply
	input  logic                   imem_valid_i,
	output logic [`PC_W-1:0]       imem_addr_o,
	output logic [`REG_IDX_W-1:0]  id_ra_idx_o,
	output logic [`REG_IDX_W-1:0]  id_rb_idx_o,
	output logic [`REG_IDX_W-1:0]  id_dest_idx_o,
	output alpha_pkg::fu_sel_e     id_fu_sel_o,
	output alpha_pkg::inst_word_u  id_ir_o,
	output logic                   id_rd_mem_o,
	output logic                   id_wr_mem_o,
	output logic                   id_ldl_mem_o,
	output logic                   id_stc_mem_o,
	output logic                   id_cond_branch_o,
	output logic                   id_uncond_branch_o,
	output logic                   id_halt_o,
	output logic                   id_cpuid_o,
	output logic                   id_illegal_o,
	output logic                   id_valid_inst_o
);

	alpha_pkg::inst_word_u  if_id_ir;            // IF/ID register
	logic                   if_id_valid_inst;

	if_stage i_if_stage (
		.clock              (clock),
		.reset_i            (reset_i),
		.stall_i            (stall_i),
		.halt_i             (id_halt_o),         // halt feeds back to fetch
		.imem_data_i        (imem_data_i),
		.imem_valid_i       (imem_valid_i),
		.imem_addr_o        (imem_addr_o),
		.if_id_ir_o         (if_id_ir),
		.if_id_valid_inst_o (if_id_valid_inst)
	);

	id_stage i_id_stage (
		.if_id_ir_i         (if_id_ir),
		.if_id_valid_inst_i (if_id_valid_inst),
		.id_ra_idx_o        (id_ra_idx_o),
		.id_rb_idx_o        (id_rb_idx_o),
		.id_dest_idx_o      (id_dest_idx_o),
		.id_fu_sel_o        (id_fu_sel_o),
		.id_ir_o            (id_ir_o),
		.id_rd_mem_o        (id_rd_mem_o),
		.id_wr_mem_o        (id_wr_mem_o),
		.id_ldl_mem_o       (id_ldl_mem_o),
		.id_stc_mem_o       (id_stc_mem_o),
		.id_cond_branch_o   (id_cond_branch_o),
		.id_uncond_branch_o (id_uncond_branch_o),
		.id_halt_o          (id_halt_o),
		.id_cpuid_o         (id_cpuid_o),
		.id_illegal_o       (id_illegal_o),
		.id_valid_inst_o    (id_valid_inst_o)
	);

endmodule

// File: src/alpha_pkg.sv
//**************************************************************************
// Alpha front end types: instruction formats union, decode mux selects,
// ALU function and functional-unit select
//**************************************************************************

`include "alpha_macros.svh"

package alpha_pkg;

	// one word, three readings
	typedef union packed {
		struct packed {
			logic [`OPCODE_W-1:0]   opcode;
			logic [`REG_IDX_W-1:0]  ra;
			logic [`REG_IDX_W-1:0]  rb;     // literal high bits when lit set
			logic [2:0]             sbz;    // literal low bits when lit set
			logic                   lit;    // operand b is the literal
			logic [`FUNC_W-1:0]     func;
			logic [`REG_IDX_W-1:0]  rc;
		} op_fmt;
		struct packed {
			logic [`OPCODE_W-1:0]   opcode;
			logic [`REG_IDX_W-1:0]  ra;
			logic [`REG_IDX_W-1:0]  rb;     // base register
			logic [`MEM_DISP_W-1:0] disp;
		} mem_fmt;
		struct packed {
			logic [`OPCODE_W-1:0]   opcode;
			logic [`REG_IDX_W-1:0]  ra;
			logic [`BR_DISP_W-1:0]  disp;   // word offset from npc
		} br_fmt;
	} inst_word_u;

	typedef enum logic [1:0] {
		OPA_IS_REGA, OPA_IS_MEM_DISP, OPA_IS_NPC, OPA_IS_NOT3
	} opa_sel_e;

	typedef enum logic [1:0] {
		OPB_IS_REGB, OPB_IS_ALU_IMM, OPB_IS_BR_DISP
	} opb_sel_e;

	typedef enum logic [1:0] {
		DEST_IS_REGC, DEST_IS_REGA, DEST_NONE
	} dest_sel_e;

	typedef enum logic [4:0] {
		ALU_ADDQ, ALU_SUBQ, ALU_AND, ALU_BIC, ALU_BIS, ALU_ORNOT,
		ALU_XOR, ALU_EQV, ALU_SRL, ALU_SLL, ALU_SRA, ALU_MULQ,
		ALU_CMPEQ, ALU_CMPLT, ALU_CMPLE, ALU_CMPULT, ALU_CMPULE
	} alu_func_e;

	typedef enum logic [`FU_SEL_W-1:0] {
		FU_NONE, FU_ALU, FU_MULT, FU_LOAD, FU_STORE,
		FU_COND_BRANCH, FU_UNCOND_BRANCH
	} fu_sel_e;

endpackage

// File: src/decoder.sv
//**************************************************************************
// Combinational Alpha subset decoder
// Opcode and function code to mux selects, ALU op, FU select and flags
//**************************************************************************

`timescale 1ns/1ps
`include "alpha_macros.svh"

module decoder (
	input  alpha_pkg::inst_word_u  inst_i,          // word from IF/ID
	input  logic                   valid_inst_i,    // low gives noop outputs
	output alpha_pkg::opa_sel_e    opa_select_o,
	output alpha_pkg::opb_sel_e    opb_select_o,
	output alpha_pkg::dest_sel_e   dest_reg_o,
	output alpha_pkg::alu_func_e   alu_func_o,
	output alpha_pkg::fu_sel_e     fu_sel_o,
	output logic                   rd_mem_o,
	output logic                   wr_mem_o,
	output logic                   ldl_mem_o,       // load locked
	output logic                   stc_mem_o,       // store conditional
	output logic                   cond_branch_o,
	output logic                   uncond_branch_o,
	output logic                   halt_o,
	output logic                   cpuid_o,         // WHAMI
	output logic                   illegal_o,
	output logic                   valid_inst_o     // valid and not illegal
);

	logic [`OPCODE_W-1:0]             opcode;      // major opcode
	logic [`REG_IDX_W+`BR_DISP_W-1:0] pal_func;    // low 26 bits of a PAL word

	assign opcode   = inst_i.op_fmt.opcode;
	assign pal_func = {inst_i.br_fmt.ra, inst_i.br_fmt.disp};

	always_comb
	begin
		// noop defaults, no register read, no writeback
		opa_select_o    = alpha_pkg::OPA_IS_NPC;
		opb_select_o    = alpha_pkg::OPB_IS_BR_DISP;
		dest_reg_o      = alpha_pkg::DEST_NONE;
		alu_func_o      = alpha_pkg::ALU_ADDQ;
		fu_sel_o        = alpha_pkg::FU_NONE;
		rd_mem_o        = 1'b0;
		wr_mem_o        = 1'b0;
		ldl_mem_o       = 1'b0;
		stc_mem_o       = 1'b0;
		cond_branch_o   = 1'b0;
		uncond_branch_o = 1'b0;
		halt_o          = 1'b0;
		cpuid_o         = 1'b0;
		illegal_o       = 1'b0;
		if (valid_inst_i)
		begin
			case (opcode)
				`PAL_INST:
				begin
					if (pal_func == `PAL_HALT)
						halt_o = 1'b1;
					else if (pal_func == `PAL_WHAMI)
					begin
						cpuid_o    = 1'b1;
						dest_reg_o = alpha_pkg::DEST_IS_REGA;   // cpu id lands in ra
					end
					else
						illegal_o = 1'b1;                       // other PAL calls
				end
				`INTA_GRP, `INTL_GRP, `INTS_GRP, `INTM_GRP:
				begin
					opa_select_o = alpha_pkg::OPA_IS_REGA;
					if (inst_i.op_fmt.lit)
						opb_select_o = alpha_pkg::OPB_IS_ALU_IMM;  // 8-bit literal
					else
						opb_select_o = alpha_pkg::OPB_IS_REGB;
					dest_reg_o = alpha_pkg::DEST_IS_REGC;
					if (opcode == `INTM_GRP)
						fu_sel_o = alpha_pkg::FU_MULT;
					else
						fu_sel_o = alpha_pkg::FU_ALU;
					case ({opcode, inst_i.op_fmt.func})
						{`INTA_GRP, `ADDQ_INST}:   alu_func_o = alpha_pkg::ALU_ADDQ;
						{`INTA_GRP, `SUBQ_INST}:   alu_func_o = alpha_pkg::ALU_SUBQ;
						{`INTA_GRP, `CMPEQ_INST}:  alu_func_o = alpha_pkg::ALU_CMPEQ;
						{`INTA_GRP, `CMPLT_INST}:  alu_func_o = alpha_pkg::ALU_CMPLT;
						{`INTA_GRP, `CMPLE_INST}:  alu_func_o = alpha_pkg::ALU_CMPLE;
						{`INTA_GRP, `CMPULT_INST}: alu_func_o = alpha_pkg::ALU_CMPULT;
						{`INTA_GRP, `CMPULE_INST}: alu_func_o = alpha_pkg::ALU_CMPULE;
						{`INTL_GRP, `AND_INST}:    alu_func_o = alpha_pkg::ALU_AND;
						{`INTL_GRP, `BIC_INST}:    alu_func_o = alpha_pkg::ALU_BIC;
						{`INTL_GRP, `BIS_INST}:    alu_func_o = alpha_pkg::ALU_BIS;
						{`INTL_GRP, `ORNOT_INST}:  alu_func_o = alpha_pkg::ALU_ORNOT;
						{`INTL_GRP, `XOR_INST}:    alu_func_o = alpha_pkg::ALU_XOR;
						{`INTL_GRP, `EQV_INST}:    alu_func_o = alpha_pkg::ALU_EQV;
						{`INTS_GRP, `SRL_INST}:    alu_func_o = alpha_pkg::ALU_SRL;
						{`INTS_GRP, `SLL_INST}:    alu_func_o = alpha_pkg::ALU_SLL;
						{`INTS_GRP, `SRA_INST}:    alu_func_o = alpha_pkg::ALU_SRA;
						{`INTM_GRP, `MULQ_INST}:   alu_func_o = alpha_pkg::ALU_MULQ;
						default:                   illegal_o  = 1'b1;   // unlisted function
					endcase
				end
				`LDA_INST, `LDQ_INST, `LDQ_L_INST, `STQ_INST, `STQ_C_INST:
				begin
					opa_select_o = alpha_pkg::OPA_IS_MEM_DISP;
					opb_select_o = alpha_pkg::OPB_IS_REGB;   // base register
					alu_func_o   = alpha_pkg::ALU_ADDQ;      // effective address
					dest_reg_o   = alpha_pkg::DEST_IS_REGA;
					case (opcode)
						`LDQ_INST:
						begin
							rd_mem_o = 1'b1;
							fu_sel_o = alpha_pkg::FU_LOAD;
						end
						`LDQ_L_INST:
						begin
							rd_mem_o  = 1'b1;
							ldl_mem_o = 1'b1;
							fu_sel_o  = alpha_pkg::FU_LOAD;
						end
						`STQ_INST:
						begin
							wr_mem_o   = 1'b1;
							dest_reg_o = alpha_pkg::DEST_NONE;   // plain store, no writeback
							fu_sel_o   = alpha_pkg::FU_STORE;
						end
						`STQ_C_INST:
						begin
							wr_mem_o  = 1'b1;
							stc_mem_o = 1'b1;                   // ra gets success flag
							fu_sel_o  = alpha_pkg::FU_STORE;
						end
						default: fu_sel_o = alpha_pkg::FU_ALU;  // LDA is just an add
					endcase
				end
				`JSR_GRP:
				begin
					opa_select_o    = alpha_pkg::OPA_IS_NOT3;
					opb_select_o    = alpha_pkg::OPB_IS_REGB;
					alu_func_o      = alpha_pkg::ALU_AND;     // word align target
					dest_reg_o      = alpha_pkg::DEST_IS_REGA;  // return address
					uncond_branch_o = 1'b1;
					fu_sel_o        = alpha_pkg::FU_UNCOND_BRANCH;
				end
				`BR_INST, `BSR_INST:
				begin
					opa_select_o    = alpha_pkg::OPA_IS_NPC;
					opb_select_o    = alpha_pkg::OPB_IS_BR_DISP;
					dest_reg_o      = alpha_pkg::DEST_IS_REGA;
					uncond_branch_o = 1'b1;
					fu_sel_o        = alpha_pkg::FU_UNCOND_BRANCH;
				end
				`ITFP_GRP, `FLTV_GRP, `FLTI_GRP, `FLTL_GRP, `MISC_GRP, `FTPI_GRP,
				`FBEQ_INST, `FBLT_INST, `FBLE_INST, `FBNE_INST, `FBGE_INST, `FBGT_INST:
					illegal_o = 1'b1;                         // FP and MISC not built
				default:
				begin
					if (opcode[5:3] == 3'b111)
					begin
						// 0x38..0x3f, integer conditional branches
						opa_select_o  = alpha_pkg::OPA_IS_NPC;
						opb_select_o  = alpha_pkg::OPB_IS_BR_DISP;
						cond_branch_o = 1'b1;
						fu_sel_o      = alpha_pkg::FU_COND_BRANCH;
					end
					else
						illegal_o = 1'b1;                     // reserved opcodes
				end
			endcase
		end
		valid_inst_o = valid_inst_i & ~illegal_o;

		// no opcode both loads and stores
		assert (!(rd_mem_o && wr_mem_o))
			else $error("decoder rd_mem and wr_mem both set, opcode %h", opcode);
		// illegal only for a real word, and that word never counts as valid
		assert (!illegal_o || (valid_inst_i && !valid_inst_o))
			else $error("decoder illegal on noop or with valid, opcode %h", opcode);
	end

endmodule

// File: src/id_stage.sv
//**************************************************************************
// Decode stage, decoder plus register index muxes
//**************************************************************************

`timescale 1ns/1ps
`include "alpha_macros.svh"

module id_stage (
	input  alpha_pkg::inst_word_u  if_id_ir_i,           // IF/ID instruction
	input  logic                   if_id_valid_inst_i,
	output logic [`REG_IDX_W-1:0]  id_ra_idx_o,          // operand a register
	output logic [`REG_IDX_W-1:0]  id_rb_idx_o,          // operand b register
	output logic [`REG_IDX_W-1:0]  id_dest_idx_o,        // zero reg if no writeback
	output alpha_pkg::fu_sel_e     id_fu_sel_o,
	output alpha_pkg::inst_word_u  id_ir_o,
	output logic                   id_rd_mem_o,
	output logic                   id_wr_mem_o,
	output logic                   id_ldl_mem_o,
	output logic                   id_stc_mem_o,
	output logic                   id_cond_branch_o,
	output logic                   id_uncond_branch_o,
	output logic                   id_halt_o,            // back to fetch
	output logic                   id_cpuid_o,
	output logic                   id_illegal_o,
	output logic                   id_valid_inst_o
);

	alpha_pkg::opa_sel_e   opa_select;
	alpha_pkg::opb_sel_e   opb_select;
	alpha_pkg::dest_sel_e  dest_select;

	assign id_ir_o = if_id_ir_i;   // word goes on unchanged

	decoder i_decoder (
		.inst_i          (if_id_ir_i),
		.valid_inst_i    (if_id_valid_inst_i),
		.opa_select_o    (opa_select),
		.opb_select_o    (opb_select),
		.dest_reg_o      (dest_select),
		.alu_func_o      (),                  // no execute stage here yet
		.fu_sel_o        (id_fu_sel_o),
		.rd_mem_o        (id_rd_mem_o),
		.wr_mem_o        (id_wr_mem_o),
		.ldl_mem_o       (id_ldl_mem_o),
		.stc_mem_o       (id_stc_mem_o),
		.cond_branch_o   (id_cond_branch_o),
		.uncond_branch_o (id_uncond_branch_o),
		.halt_o          (id_halt_o),
		.cpuid_o         (id_cpuid_o),
		.illegal_o       (id_illegal_o),
		.valid_inst_o    (id_valid_inst_o)
	);

	// operands not read from a register point at r31, always ready
	assign id_ra_idx_o = (opa_select == alpha_pkg::OPA_IS_REGA) ?
		if_id_ir_i.op_fmt.ra : `ZERO_REG;
	assign id_rb_idx_o = (opb_select == alpha_pkg::OPB_IS_REGB) ?
		if_id_ir_i.op_fmt.rb : `ZERO_REG;

	always_comb
	begin
		case (dest_select)
			alpha_pkg::DEST_IS_REGC: id_dest_idx_o = if_id_ir_i.op_fmt.rc;   // operate
			alpha_pkg::DEST_IS_REGA: id_dest_idx_o = if_id_ir_i.op_fmt.ra;   // loads, links
			default:                 id_dest_idx_o = `ZERO_REG;
		endcase
	end

endmodule

// File: src/if_stage.sv
//**************************************************************************
// Fetch stage, PC, halt latch and IF/ID pipeline register
//**************************************************************************

`timescale 1ns/1ps
`include "alpha_macros.svh"

module if_stage (
	input  logic                   clock,
	input  logic                   reset_i,
	input  logic                   stall_i,             // back end freeze level
	input  logic                   halt_i,              // halt seen at decode
	input  alpha_pkg::inst_word_u  imem_data_i,
	input  logic                   imem_valid_i,
	output logic [`PC_W-1:0]       imem_addr_o,
	output alpha_pkg::inst_word_u  if_id_ir_o,
	output logic                   if_id_valid_inst_o
);

	logic [`PC_W-1:0] pc_r;
	logic             halted_r;   // sticky until reset
	logic             freeze;     // stall or halted
	logic             fetch_en;   // take the returned word this edge

	assign freeze      = stall_i | halted_r;
	assign fetch_en    = ~freeze & ~halt_i;
	assign imem_addr_o = pc_r;

	//**********************************************************************
	// control state
	//**********************************************************************
	always_ff @(posedge clock)
	begin
		if (reset_i)
		begin
			pc_r               <= `RESET_PC;
			halted_r           <= 1'b0;
			if_id_valid_inst_o <= 1'b0;
		end
		else if (halt_i | halted_r)
		begin
			halted_r           <= 1'b1;
			if_id_valid_inst_o <= 1'b0;           // decode shows a noop, pc parks
		end
		else if (fetch_en)
		begin
			pc_r               <= pc_r + 'd4;     // sequential only
			if_id_valid_inst_o <= imem_valid_i;
		end
	end

	// instruction payload
	always_ff @(posedge clock)
	begin
		if (fetch_en)
			if_id_ir_o <= imem_data_i;
	end

	//**********************************************************************
	// checks
	//**********************************************************************
	assert property (@(posedge clock) disable iff (reset_i) stall_i |=> $stable(pc_r))
		else $error("if_stage pc moved during stall");

endmodule

// File: tb.f
+incdir+include
+incdir+dv
src/alpha_pkg.sv
src/decoder.sv
src/id_stage.sv
src/if_stage.sv
src/alpha_frontend.sv
dv/tb_alpha_frontend.sv
